/* design/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

  localparam int addr_w = 7;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  typedef logic [addr_w-1:0] addr_t; // byte address
  typedef logic [data_w-1:0] data_t;
  typedef logic [strb_w-1:0] strb_t;

  // only resp_okay is ever returned
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_t;

  typedef struct packed {
    resp_t resp;
  } b_payload_t;

  typedef struct packed {
    resp_t resp;
    data_t data;
  } r_payload_t;

endpackage

`default_nettype wire

/* design/reg_map_pkg.sv */
`default_nettype none

package reg_map_pkg;

  // word index sits right above the byte offset
  localparam int addr_lsb    = 2;
  localparam int reg_index_w = 5;

  typedef logic [reg_index_w-1:0] reg_index_t;

  // one write into the bank with a single-cycle en strobe
  typedef struct packed {
    logic                en;
    reg_index_t          index;
    axi_lite_pkg::data_t data;
    axi_lite_pkg::strb_t strb;
  } reg_wr_t;

endpackage

`default_nettype wire

/* design/axi_resp_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_resp_slot #(
  parameter type payload_t = logic
) (
  input  wire           S_AXI_ACLK,
  input  wire           S_AXI_ARESETN,
  input  wire           load,
  input  wire payload_t load_payload,
  input  wire           ready,
  output logic          valid,
  output logic          free,
  output payload_t      payload
);

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1; // load wins over ready
    end else if (ready) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (load) payload <= load_payload;
  end

  assign free = !valid || ready; // empty at the next edge

endmodule

`default_nettype wire

/* design/axi_write_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_write_channel (
  input  wire                       S_AXI_ACLK,
  input  wire                       S_AXI_ARESETN,
  input  wire axi_lite_pkg::addr_t  awaddr,
  input  wire                       awvalid,
  input  wire axi_lite_pkg::data_t  wdata,
  input  wire axi_lite_pkg::strb_t  wstrb,
  input  wire                       wvalid,
  input  wire                       bready,
  output logic                      awready,
  output logic                      wready,
  output axi_lite_pkg::resp_t       bresp,
  output logic                      bvalid,
  output reg_map_pkg::reg_wr_t      wr_req
);

  import axi_lite_pkg::*;
  import reg_map_pkg::*;

  logic       ready_q; // shared aw/w ready pulse
  addr_t      awaddr_q;
  logic       b_free;
  logic       hs;
  b_payload_t b_load;
  b_payload_t b_out;

  // both valids present, no pulse pending, room for the response
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= !ready_q && awvalid && wvalid && b_free;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!ready_q && awvalid && wvalid && b_free) awaddr_q <= awaddr;
  end

  assign awready = ready_q;
  assign wready  = ready_q;
  assign hs      = ready_q && awvalid && wvalid;

  assign wr_req.en    = hs;
  assign wr_req.index = awaddr_q[addr_lsb +: reg_index_w];
  assign wr_req.data  = wdata;
  assign wr_req.strb  = wstrb;

  assign b_load.resp = resp_okay;

  axi_resp_slot #(.payload_t(b_payload_t)) u_b_slot (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .load         (hs),
    .load_payload (b_load),
    .ready        (bready),
    .valid        (bvalid),
    .free         (b_free),
    .payload      (b_out)
  );

  assign bresp = b_out.resp;

endmodule

`default_nettype wire

/* design/axi_read_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_channel (
  input  wire                        S_AXI_ACLK,
  input  wire                        S_AXI_ARESETN,
  input  wire axi_lite_pkg::addr_t   araddr,
  input  wire                        arvalid,
  input  wire                        rready,
  input  wire axi_lite_pkg::data_t   rd_data,
  output logic                       arready,
  output reg_map_pkg::reg_index_t    rd_index,
  output axi_lite_pkg::r_payload_t   r_payload,
  output logic                       rvalid
);

  import axi_lite_pkg::*;
  import reg_map_pkg::*;

  addr_t      araddr_q;
  logic       r_free;
  logic       hs;
  r_payload_t r_load;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      arready <= 1'b0;
    end else begin
      arready <= !arready && arvalid && r_free;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!arready && arvalid && r_free) araddr_q <= araddr;
  end

  assign rd_index = araddr_q[addr_lsb +: reg_index_w];
  assign hs       = arready && arvalid;

  // bank data sampled at the end of the arready pulse
  assign r_load.resp = resp_okay;
  assign r_load.data = rd_data;

  axi_resp_slot #(.payload_t(r_payload_t)) u_r_slot (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .load         (hs),
    .load_payload (r_load),
    .ready        (rready),
    .valid        (rvalid),
    .free         (r_free),
    .payload      (r_payload)
  );

endmodule

`default_nettype wire

/* design/reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_bank #(
  parameter int num_regs = 32
) (
  input  wire                          S_AXI_ACLK,
  input  wire                          S_AXI_ARESETN,
  input  wire reg_map_pkg::reg_wr_t    wr_req,
  input  wire reg_map_pkg::reg_index_t rd_index,
  output axi_lite_pkg::data_t          rd_data
);

  import axi_lite_pkg::*;
  import reg_map_pkg::*;

  data_t regs [num_regs];
  logic  wr_in_range;
  logic  rd_in_range;

  assign wr_in_range = int'(wr_req.index) < num_regs;
  assign rd_in_range = int'(rd_index) < num_regs;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_req.en && wr_in_range) begin
      for (int b = 0; b < strb_w; b++) begin
        if (wr_req.strb[b]) regs[wr_req.index][b*8 +: 8] <= wr_req.data[b*8 +: 8];
      end
    end
  end

  always_comb begin
    rd_data = '0; // unmapped index reads zero
    if (rd_in_range) rd_data = regs[rd_index];
  end

endmodule

`default_nettype wire

/* design/axi_lite_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_regs #(
  parameter int num_regs = 32
) (
  input  wire                      S_AXI_ACLK,
  input  wire                      S_AXI_ARESETN,
  input  wire axi_lite_pkg::addr_t s_axi_awaddr,
  input  wire                      s_axi_awvalid,
  output logic                     s_axi_awready,
  input  wire axi_lite_pkg::data_t s_axi_wdata,
  input  wire axi_lite_pkg::strb_t s_axi_wstrb,
  input  wire                      s_axi_wvalid,
  output logic                     s_axi_wready,
  output axi_lite_pkg::resp_t      s_axi_bresp,
  output logic                     s_axi_bvalid,
  input  wire                      s_axi_bready,
  input  wire axi_lite_pkg::addr_t s_axi_araddr,
  input  wire                      s_axi_arvalid,
  output logic                     s_axi_arready,
  output axi_lite_pkg::data_t      s_axi_rdata,
  output axi_lite_pkg::resp_t      s_axi_rresp,
  output logic                     s_axi_rvalid,
  input  wire                      s_axi_rready
);

  import axi_lite_pkg::*;
  import reg_map_pkg::*;

  reg_wr_t    wr_req;
  reg_index_t rd_index;
  data_t      rd_data;
  r_payload_t r_payload;

  axi_write_channel u_wr (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .awaddr       (s_axi_awaddr),
    .awvalid      (s_axi_awvalid),
    .wdata        (s_axi_wdata),
    .wstrb        (s_axi_wstrb),
    .wvalid       (s_axi_wvalid),
    .bready       (s_axi_bready),
    .awready      (s_axi_awready),
    .wready       (s_axi_wready),
    .bresp        (s_axi_bresp),
    .bvalid       (s_axi_bvalid),
    .wr_req       (wr_req)
  );

  axi_read_channel u_rd (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .araddr       (s_axi_araddr),
    .arvalid      (s_axi_arvalid),
    .rready       (s_axi_rready),
    .rd_data      (rd_data),
    .arready      (s_axi_arready),
    .rd_index     (rd_index),
    .r_payload    (r_payload),
    .rvalid       (s_axi_rvalid)
  );

  reg_bank #(.num_regs(num_regs)) u_bank (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .wr_req       (wr_req),
    .rd_index     (rd_index),
    .rd_data      (rd_data)
  );

  assign s_axi_rdata = r_payload.data;
  assign s_axi_rresp = r_payload.resp;

endmodule

`default_nettype wire

/* testbench/axi_lite_regs_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_regs_assert (
  input wire                      S_AXI_ACLK,
  input wire                      S_AXI_ARESETN,
  input wire                      s_axi_awready,
  input wire                      s_axi_wready,
  input wire                      s_axi_bvalid,
  input wire                      s_axi_bready,
  input wire                      s_axi_arready,
  input wire                      s_axi_rvalid,
  input wire                      s_axi_rready,
  input wire axi_lite_pkg::data_t s_axi_rdata
);

  b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else $error("bvalid dropped before bready");

  // data must not move under a stalled R
  r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
    else $error("rvalid or rdata changed before rready");

  ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_awready == s_axi_wready)
    else $error("awready and wready differ");

  reset_quiet: assert property (@(posedge S_AXI_ACLK) !S_AXI_ARESETN |=>
    !(s_axi_awready || s_axi_wready || s_axi_bvalid || s_axi_arready || s_axi_rvalid))
    else $error("handshake output high during reset");

endmodule

`default_nettype wire

/* testbench/tb_axi_lite_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_lite_regs;

  import axi_lite_pkg::*;

  localparam int num_regs    = 32;
  localparam int num_tests   = 5;
  localparam int watchdog_ns = num_tests * 300 * 4;

  logic  S_AXI_ACLK;
  logic  S_AXI_ARESETN;
  addr_t s_axi_awaddr;
  logic  s_axi_awvalid;
  logic  s_axi_awready;
  data_t s_axi_wdata;
  strb_t s_axi_wstrb;
  logic  s_axi_wvalid;
  logic  s_axi_wready;
  resp_t s_axi_bresp;
  logic  s_axi_bvalid;
  logic  s_axi_bready;
  addr_t s_axi_araddr;
  logic  s_axi_arvalid;
  logic  s_axi_arready;
  data_t s_axi_rdata;
  resp_t s_axi_rresp;
  logic  s_axi_rvalid;
  logic  s_axi_rready;

  data_t model [num_regs]; // expected register contents
  int    errors;
  int    failed_tests;

  axi_lite_regs #(.num_regs(num_regs)) u_dut (.*);

  bind axi_lite_regs axi_lite_regs_assert u_assert (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .s_axi_awready(s_axi_awready),
    .s_axi_wready (s_axi_wready),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bready (s_axi_bready),
    .s_axi_arready(s_axi_arready),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rready (s_axi_rready),
    .s_axi_rdata  (s_axi_rdata)
  );

  initial begin
    S_AXI_ACLK = 1'b0;
    forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  task automatic check_eq(input data_t got, input data_t exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s (got %h, expected %h)", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic next_cycle(); // inputs change 1 ns after the edge
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  // byte lanes with strobe set take the new data
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
    data_t w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return w;
  endfunction

  task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    s_axi_bready  = 1'b1;
    while (!s_axi_awready) next_cycle();
    check_eq(32'(s_axi_wready), 1, "wready together with awready");
    next_cycle(); // handshake edge
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    while (!s_axi_bvalid) next_cycle();
    check_eq(32'(s_axi_bresp), 32'(resp_okay), "bresp");
    model[addr[6:2]] = merge_bytes(model[addr[6:2]], data, strb);
    next_cycle();
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input addr_t addr, input string msg);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    s_axi_rready  = 1'b1;
    while (!s_axi_arready) next_cycle();
    next_cycle();
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid) next_cycle();
    check_eq(s_axi_rdata, model[addr[6:2]], msg);
    check_eq(32'(s_axi_rresp), 32'(resp_okay), "rresp");
    next_cycle();
    s_axi_rready = 1'b0;
  endtask

  task automatic read_after_reset();
    for (int i = 0; i < num_regs; i++) axi_read(addr_t'(i * 4), "value after reset");
  endtask

  task automatic full_word_writes();
    for (int i = 0; i < num_regs; i++) axi_write(addr_t'(i * 4), $urandom(), 4'hf);
    for (int i = 0; i < num_regs; i++) axi_read(addr_t'(i * 4), "full word readback");
  endtask

  task automatic strobed_writes();
    strb_t strb;
    for (int i = 0; i < 8; i++) begin
      strb = strb_t'($urandom());
      axi_write(addr_t'(i * 4), 32'ha5c3_5a3c, 4'hf); // known word first
      axi_write(addr_t'(i * 4), $urandom(), strb);
      axi_read(addr_t'(i * 4), "strobed write");
    end
  endtask

  task automatic offset_aliasing();
    for (int off = 0; off < 4; off++) begin
      axi_write(addr_t'((10 + off) * 4 + off), $urandom(), 4'hf);
      axi_read(addr_t'((10 + off) * 4 + 3 - off), "aliased byte offset");
    end
  endtask

  task automatic response_stalls();
    data_t held;
    int    n;
    s_axi_bready  = 1'b0;
    s_axi_awaddr  = addr_t'(20 * 4);
    s_axi_wdata   = $urandom();
    s_axi_wstrb   = 4'hf;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    while (!s_axi_awready) next_cycle();
    next_cycle();
    model[20] = s_axi_wdata;
    s_axi_awaddr = addr_t'(21 * 4); // second write queued behind the pending B
    s_axi_wdata  = $urandom();
    repeat (4) begin
      next_cycle();
      check_eq(32'(s_axi_bvalid), 1, "bvalid held without bready");
      check_eq(32'(s_axi_awready), 0, "awready while B pending");
      check_eq(32'(s_axi_wready), 0, "wready while B pending");
    end
    s_axi_bready = 1'b1;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!s_axi_bvalid && n < 10);
    check_eq(n, 2, "cycles from bready to the next bvalid");
    check_eq(32'(s_axi_bresp), 32'(resp_okay), "bresp of queued write");
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    model[21] = s_axi_wdata;
    next_cycle();
    s_axi_bready = 1'b0;
    axi_read(addr_t'(20 * 4), "first write under back-pressure");
    axi_read(addr_t'(21 * 4), "queued write");
    // read response held while rready stays low
    s_axi_araddr  = addr_t'(20 * 4);
    s_axi_arvalid = 1'b1;
    while (!s_axi_arready) next_cycle();
    next_cycle();
    s_axi_arvalid = 1'b0;
    held = s_axi_rdata;
    check_eq(32'(s_axi_rvalid), 1, "rvalid after read handshake");
    check_eq(held, model[20], "held read data");
    repeat (3) begin
      next_cycle();
      check_eq(32'(s_axi_rvalid), 1, "rvalid held without rready");
      check_eq(s_axi_rdata, held, "rdata held without rready");
    end
    axi_write(addr_t'(20 * 4), ~held, 4'hf);
    check_eq(s_axi_rdata, held, "rdata after register update");
    s_axi_rready = 1'b1;
    next_cycle();
    s_axi_rready = 1'b0;
    check_eq(32'(s_axi_rvalid), 0, "rvalid after rready");
    axi_read(addr_t'(20 * 4), "read after held response");
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - errors_before);
      failed_tests++;
    end
  endtask

  initial begin
    int e0;
    void'($urandom(71));
    errors        = 0;
    failed_tests  = 0;
    S_AXI_ARESETN = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    for (int i = 0; i < num_regs; i++) model[i] = '0;
    repeat (3) @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARESETN = 1'b1;
    e0 = errors;
    read_after_reset();
    report_test("reset", e0);
    e0 = errors;
    full_word_writes();
    report_test("full_word", e0);
    e0 = errors;
    strobed_writes();
    report_test("strobes", e0);
    e0 = errors;
    offset_aliasing();
    report_test("aliasing", e0);
    e0 = errors;
    response_stalls();
    report_test("back_pressure", e0);
    $display("tests %0d, failed %0d, check errors %0d", num_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("ERROR: simulation timed out after %0d ns", watchdog_ns);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
design/axi_lite_pkg.sv
design/reg_map_pkg.sv
design/axi_resp_slot.sv
design/axi_write_channel.sv
design/axi_read_channel.sv
design/reg_bank.sv
design/axi_lite_regs.sv
testbench/axi_lite_regs_assert.sv
testbench/tb_axi_lite_regs.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_axi_lite_regs -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"
